// ==== files.f ====
logic/bpu_pkg.sv
logic/inst_decode.sv
logic/tage_predictor.sv
logic/btb.sv
logic/return_stack.sv
logic/bpu_top.sv
sim/bpu_checker.sv
sim/bpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= bpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/bpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_tb import bpu_pkg::*; ();

    localparam int RESET_CYCLES = 4;
    localparam logic [XLEN-1:0] INST_ALU   = 32'h0010_0093; // addi x1, x0, 1
    localparam logic [XLEN-1:0] INST_BEQ16 = 32'h0000_0863; // beq x0, x0, +16
    localparam logic [XLEN-1:0] INST_JAL32 = 32'h0200_00ef; // jal x1, +32
    localparam logic [XLEN-1:0] INST_RET   = 32'h0000_8067; // jalr x0, 0(x1)

    typedef struct packed {
        logic [127:0]    name;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        logic            upd_valid;
        logic            upd_taken;
        logic            upd_correct;
        logic            upd_ret;
        logic [XLEN-1:0] upd_pc;
        logic [XLEN-1:0] upd_target;
        logic            push;
        logic [XLEN-1:0] push_addr;
        logic            stall;
        logic            exp_redirect;
        logic            exp_taken;
        logic [XLEN-1:0] exp_target;
        logic            chk_prov;
        provider_e       exp_prov;
    } step_t;

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] fetch_inst;
    logic            call_push;
    logic [XLEN-1:0] call_ret_addr;
    logic            stall;
    ex_update_t      update;
    prediction_t     prediction;

    step_t                 steps[$];
    step_t                 cur;
    logic                  active;
    logic                  table_ready;
    logic [HIST_WIDTH-1:0] hist_model;  // mirrors the DUT history
    logic [HIST_WIDTH-1:0] exp_hist;    // history seen by the current fetch
    int                    test_count;
    int                    error_count;
    int                    cycles;

    bpu_top bpu_top_i (
        .clk             (clk),
        .rst             (rst),
        .fetch_pc_i      (fetch_pc),
        .fetch_inst_i    (fetch_inst),
        .call_push_i     (call_push),
        .call_ret_addr_i (call_ret_addr),
        .stall_i         (stall),
        .update_i        (update),
        .prediction_o    (prediction)
    );

    bpu_checker bpu_checker_i (
        .clk            (clk),
        .active_i       (active),
        .name_i         (cur.name),
        .exp_redirect_i (cur.exp_redirect),
        .exp_taken_i    (cur.exp_taken),
        .exp_target_i   (cur.exp_target),
        .chk_prov_i     (cur.chk_prov),
        .exp_prov_i     (cur.exp_prov),
        .exp_hist_i     (exp_hist),
        .prediction_i   (prediction),
        .test_count_o   (test_count),
        .error_count_o  (error_count)
    );

    task automatic add_step(input logic [127:0] name, input logic [XLEN-1:0] pc,
                            input logic [XLEN-1:0] inst, input logic redirect,
                            input logic taken, input logic [XLEN-1:0] target);
        step_t s;
        s              = '0;
        s.name         = name;
        s.pc           = pc;
        s.inst         = inst;
        s.exp_redirect = redirect;
        s.exp_taken    = taken;
        s.exp_target   = target;
        s.exp_prov     = PROV_BIMODAL;
        steps.push_back(s);
    endtask

    task automatic with_update(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] target,
                               input logic taken, input logic correct, input logic ret);
        int n;
        n                    = steps.size() - 1;
        steps[n].upd_valid   = 1'b1;
        steps[n].upd_pc      = pc;
        steps[n].upd_target  = target;
        steps[n].upd_taken   = taken;
        steps[n].upd_correct = correct;
        steps[n].upd_ret     = ret;
    endtask

    task automatic with_push(input logic [XLEN-1:0] addr, input logic stall_lvl);
        int n;
        n                  = steps.size() - 1;
        steps[n].push      = 1'b1;
        steps[n].push_addr = addr;
        steps[n].stall     = stall_lvl;
    endtask

    task automatic with_provider(input provider_e prov);
        steps[steps.size()-1].chk_prov = 1'b1;
        steps[steps.size()-1].exp_prov = prov;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst           = 1'b1;
        fetch_pc      = '0;
        fetch_inst    = '0;
        call_push     = 1'b0;
        call_ret_addr = '0;
        stall         = 1'b0;
        update        = '0;
        active        = 1'b0;
        cur           = '0;
        hist_model    = '0;
        exp_hist      = '0;
        table_ready   = 1'b0;

        add_step("alu_reset", 32'h100, INST_ALU, 1'b0, 1'b0, 32'h104);
        add_step("br_untrained", 32'h240, INST_BEQ16, 1'b1, 1'b0, 32'h244);
        with_provider(PROV_BIMODAL);
        // taken miss at history 0 allocates T1 idx 0x00, tag 0x005
        add_step("br_mispredict", 32'h500, INST_BEQ16, 1'b1, 1'b0, 32'h504);
        with_provider(PROV_BIMODAL);
        with_update(32'h500, 32'h510, 1'b1, 1'b0, 1'b0);
        for (int i = 0; i < HIST_WIDTH; i++) begin
            add_step("hist_flush", 32'h700, INST_ALU, 1'b0, 1'b0, 32'h704);
            with_update(32'h680, 32'h690, 1'b0, 1'b1, 1'b0);  // shifts a zero in
        end
        add_step("br_t1_hit", 32'h500, INST_BEQ16, 1'b1, 1'b1, 32'h510);
        with_provider(PROV_T1);
        add_step("jal_no_btb", 32'h300, INST_JAL32, 1'b1, 1'b1, 32'h320);
        add_step("jal_btb_fill", 32'h300, INST_JAL32, 1'b1, 1'b1, 32'h320);
        with_update(32'h300, 32'h400, 1'b1, 1'b1, 1'b0);
        add_step("jal_btb_hit", 32'h300, INST_JAL32, 1'b1, 1'b1, 32'h400);
        add_step("br_train_1", 32'h240, INST_BEQ16, 1'b1, 1'b0, 32'h244);
        with_update(32'h240, 32'h250, 1'b1, 1'b1, 1'b0);
        add_step("br_train_2", 32'h240, INST_BEQ16, 1'b1, 1'b1, 32'h250);
        with_update(32'h240, 32'h250, 1'b1, 1'b1, 1'b0);
        add_step("br_trained", 32'h240, INST_BEQ16, 1'b1, 1'b1, 32'h250);
        with_provider(PROV_BIMODAL);
        add_step("push_a", 32'h800, INST_ALU, 1'b0, 1'b0, 32'h804);
        with_push(32'ha00, 1'b0);
        add_step("push_b", 32'h800, INST_ALU, 1'b0, 1'b0, 32'h804);
        with_push(32'hb00, 1'b0);
        add_step("ret_b", 32'h900, INST_RET, 1'b1, 1'b1, 32'hb00);
        with_update(32'h900, 32'hb00, 1'b1, 1'b1, 1'b1);
        add_step("ret_a", 32'h900, INST_RET, 1'b1, 1'b1, 32'ha00);
        with_update(32'h900, 32'ha00, 1'b1, 1'b1, 1'b1);
        add_step("ret_empty", 32'h900, INST_RET, 1'b1, 1'b0, 32'h904);
        add_step("push_d", 32'h800, INST_ALU, 1'b0, 1'b0, 32'h804);
        with_push(32'hd00, 1'b0);
        add_step("push_stalled", 32'h800, INST_ALU, 1'b0, 1'b0, 32'h804);
        with_push(32'hc00, 1'b1);
        add_step("ret_after_stall", 32'h900, INST_RET, 1'b1, 1'b1, 32'hd00);
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;

        for (int i = 0; i < steps.size(); i++) begin
            @(posedge clk);
            #1;
            cur                    = steps[i];
            fetch_pc               = cur.pc;
            fetch_inst             = cur.inst;
            call_push              = cur.push;
            call_ret_addr          = cur.push_addr;
            stall                  = cur.stall;
            update.valid           = cur.upd_valid;
            update.taken           = cur.upd_taken;
            update.correct         = cur.upd_correct;
            update.pc              = cur.upd_pc;
            update.target          = cur.upd_target;
            update.ret             = cur.upd_ret;
            update.meta.provider   = PROV_BIMODAL;  // every update here came from bimodal
            update.meta.history    = hist_model;
            exp_hist               = hist_model;
            if (cur.upd_valid) begin
                hist_model = {hist_model[HIST_WIDTH-2:0], cur.upd_taken};
            end
            active = 1'b1;
        end
        @(posedge clk);
        #1;
        active    = 1'b0;
        update    = '0;
        call_push = 1'b0;
        stall     = 1'b0;
        @(posedge clk);
        $display("tests run %0d, tests failed %0d", test_count, error_count);
        if (error_count == 0 && test_count == steps.size()) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // run limit from the table length
    initial begin
        cycles = 0;
        wait (table_ready);
        while (cycles < steps.size() + RESET_CYCLES + 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/bpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_checker import bpu_pkg::*; #(
    parameter int SAMPLE_DELAY = 3
) (
    input  wire logic                  clk,
    input  wire logic                  active_i,
    input  wire logic [127:0]          name_i,
    input  wire logic                  exp_redirect_i,
    input  wire logic                  exp_taken_i,
    input  wire logic [XLEN-1:0]       exp_target_i,
    input  wire logic                  chk_prov_i,
    input  wire provider_e             exp_prov_i,
    input  wire logic [HIST_WIDTH-1:0] exp_hist_i,
    input  wire prediction_t           prediction_i,
    output int                         test_count_o,
    output int                         error_count_o
);

    string test_name;
    logic  step_bad;

    // packed name to a string without the zero padding
    function automatic string name_text(input logic [127:0] v);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, v[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic compare(input string field, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("Error %s %s expected %h actual %h", test_name, field, exp, act);
            step_bad = 1'b1;
        end
    endtask

    initial begin
        test_count_o  = 0;
        error_count_o = 0;
    end

    // sample late in the cycle, inputs settled at +1 ns
    always @(posedge clk) begin
        #SAMPLE_DELAY;
        if (active_i) begin
            test_name = name_text(name_i);
            step_bad  = 1'b0;
            compare("redirect", XLEN'(exp_redirect_i), XLEN'(prediction_i.redirect));
            compare("taken", XLEN'(exp_taken_i), XLEN'(prediction_i.taken));
            compare("target", exp_target_i, prediction_i.target);
            compare("history", XLEN'(exp_hist_i), XLEN'(prediction_i.meta.history));
            if (chk_prov_i) begin
                compare("provider", XLEN'(exp_prov_i), XLEN'(prediction_i.meta.provider));
            end
            test_count_o++;
            if (step_bad) begin
                error_count_o++;
            end else begin
                $display("ok    %s", test_name);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/bpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_top import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 64
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [XLEN-1:0] fetch_pc_i,
    input  wire logic [XLEN-1:0] fetch_inst_i,
    input  wire logic            call_push_i,
    input  wire logic [XLEN-1:0] call_ret_addr_i,
    input  wire logic            stall_i,
    input  wire ex_update_t      update_i,
    output prediction_t          prediction_o
);

    decode_t         dec;
    logic            dir_taken;
    pred_meta_t      dir_meta;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic [XLEN-1:0] ras_top;
    logic            ras_nonempty;
    logic            ras_pop;
    logic [XLEN-1:0] pc_plus4;

    // only a taken return leaves the stack
    assign ras_pop = update_i.valid && update_i.ret && update_i.taken;

    inst_decode u_decode (
        .inst_i   (fetch_inst_i),
        .decode_o (dec)
    );

    tage_predictor #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES)
    ) u_tage (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_pc_i),
        .taken_o  (dir_taken),
        .meta_o   (dir_meta),
        .update_i (update_i)
    );

    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_pc_i),
        .hit_o    (btb_hit),
        .target_o (btb_target),
        .update_i (update_i)
    );

    return_stack #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (call_push_i),
        .push_addr_i (call_ret_addr_i),
        .pop_i       (ras_pop),
        .stall_i     (stall_i),
        .top_o       (ras_top),
        .nonempty_o  (ras_nonempty)
    );

    assign pc_plus4 = fetch_pc_i + XLEN'(4);

    always_comb begin
        prediction_o.redirect = (dec.cls != CLS_NONE);
        prediction_o.taken    = 1'b0;
        prediction_o.target   = pc_plus4;  // fall through unless taken
        prediction_o.meta     = dir_meta;
        case (dec.cls)
            CLS_RET: begin
                if (ras_nonempty) begin
                    prediction_o.taken  = 1'b1;
                    prediction_o.target = ras_top;
                end
            end
            CLS_JAL: begin
                prediction_o.taken  = 1'b1;
                prediction_o.target = btb_hit ? btb_target : fetch_pc_i + dec.jal_off;
            end
            CLS_BRANCH: begin
                prediction_o.taken = dir_taken;
                if (dir_taken) begin
                    prediction_o.target = btb_hit ? btb_target
                                                  : fetch_pc_i + dec.branch_off;
                end
            end
            default: ;  // plain jalr stays not taken
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/return_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

module return_stack import bpu_pkg::*; #(
    parameter int RAS_DEPTH = 64
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            push_i,
    input  wire logic [XLEN-1:0] push_addr_i,
    input  wire logic            pop_i,
    input  wire logic            stall_i,
    output logic [XLEN-1:0]      top_o,
    output logic                 nonempty_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;  // counts 0 .. RAS_DEPTH

    logic [XLEN-1:0]  stack_mem [RAS_DEPTH];
    logic [PTR_W-1:0] sp;              // next free slot
    logic [PTR_W-1:0] sp_popped;
    logic [PTR_W-1:0] top_ptr;
    logic             do_pop;
    logic             do_push;

    assign nonempty_o = (sp != '0);

    assign do_pop    = pop_i && !stall_i && nonempty_o;  // pop on empty ignored
    assign sp_popped = do_pop ? sp - 1'b1 : sp;
    // full check is after the pop, so push+pop keeps depth
    assign do_push   = push_i && !stall_i && (sp_popped < PTR_W'(RAS_DEPTH));

    assign top_ptr = sp - 1'b1;
    assign top_o   = stack_mem[top_ptr[IDX_W-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp <= '0;
        end else if (do_push) begin
            sp <= sp_popped + 1'b1;
        end else begin
            sp <= sp_popped;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[sp_popped[IDX_W-1:0]] <= push_addr_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb import bpu_pkg::*; #(
    parameter int BTB_ENTRIES = 256
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [XLEN-1:0] pc_i,
    output logic                 hit_o,
    output logic [XLEN-1:0]      target_o,
    input  wire ex_update_t      update_i
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = XLEN - IDX_W - 2;  // word aligned, rest is tag

    logic [TAG_W-1:0] tag_mem    [BTB_ENTRIES];
    logic [XLEN-1:0]  target_mem [BTB_ENTRIES];
    logic             valid_mem  [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[XLEN-1:IDX_W+2];

    // combinational lookup
    assign hit_o    = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];

    assign wr_idx = update_i.pc[IDX_W+1:2];
    assign wr_tag = update_i.pc[XLEN-1:IDX_W+2];
    assign wr_en  = update_i.valid && update_i.taken; // fill on taken only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_mem[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_mem[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= update_i.target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/tage_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tage_predictor import bpu_pkg::*; #(
    parameter int BIMODAL_ENTRIES = 512
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [XLEN-1:0] pc_i,
    output logic                 taken_o,
    output pred_meta_t           meta_o,
    input  wire ex_update_t      update_i
);

    localparam int BIM_IDX_W    = $clog2(BIMODAL_ENTRIES);
    localparam int TAGE_ENTRIES = 2 ** TAGE_INDEX_WIDTH;

    logic [HIST_WIDTH-1:0] ghist;

    logic [1:0]           bim_ctr [BIMODAL_ENTRIES];
    logic [1:0]           t0_ctr  [TAGE_ENTRIES];
    logic [1:0]           t1_ctr  [TAGE_ENTRIES];
    logic [TAG_WIDTH-1:0] t0_tag  [TAGE_ENTRIES];
    logic [TAG_WIDTH-1:0] t1_tag  [TAGE_ENTRIES];
    logic                 t0_vld  [TAGE_ENTRIES];
    logic                 t1_vld  [TAGE_ENTRIES];

    // lookup side
    logic [BIM_IDX_W-1:0]        bim_idx;
    logic [TAGE_INDEX_WIDTH-1:0] t0_idx;
    logic [TAGE_INDEX_WIDTH-1:0] t1_idx;
    logic [TAG_WIDTH-1:0]        t0_tag_q;
    logic [TAG_WIDTH-1:0]        t1_tag_q;
    logic                        t0_hit;
    logic                        t1_hit;

    // training side
    logic [BIM_IDX_W-1:0]        u_bim_idx;
    logic [TAGE_INDEX_WIDTH-1:0] u_t0_idx;
    logic [TAGE_INDEX_WIDTH-1:0] u_t1_idx;
    logic [TAG_WIDTH-1:0]        u_t0_tag;
    logic [TAG_WIDTH-1:0]        u_t1_tag;
    logic [HIST_WIDTH-1:0]       u_hist;
    logic                        bim_miss;
    logic                        alloc_t1;
    logic                        alloc_t0;

    function automatic logic [1:0] sat_ctr(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            sat_ctr = (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end else begin
            sat_ctr = (ctr == 2'b00) ? ctr : ctr - 2'b01;
        end
    endfunction

    assign bim_idx  = pc_i[BIM_IDX_W:1];
    assign t0_idx   = pc_i[7:0] ^ ghist[7:0];
    assign t1_idx   = pc_i[7:0] ^ ghist[15:8];
    assign t0_tag_q = pc_i[17:8] ^ ghist[15:6];
    assign t1_tag_q = pc_i[17:8] ^ {{(TAG_WIDTH-8){1'b0}}, ghist[7:0]};

    assign t0_hit = t0_vld[t0_idx] && (t0_tag[t0_idx] == t0_tag_q);
    assign t1_hit = t1_vld[t1_idx] && (t1_tag[t1_idx] == t1_tag_q);

    // longest history wins
    always_comb begin
        if (t1_hit) begin
            taken_o         = t1_ctr[t1_idx][1];
            meta_o.provider = PROV_T1;
        end else if (t0_hit) begin
            taken_o         = t0_ctr[t0_idx][1];
            meta_o.provider = PROV_T0;
        end else begin
            taken_o         = bim_ctr[bim_idx][1];
            meta_o.provider = PROV_BIMODAL;
        end
    end

    assign meta_o.history = ghist;

    // same hashing, but with the history seen at predict time
    assign u_hist    = update_i.meta.history;
    assign u_bim_idx = update_i.pc[BIM_IDX_W:1];
    assign u_t0_idx  = update_i.pc[7:0] ^ u_hist[7:0];
    assign u_t1_idx  = update_i.pc[7:0] ^ u_hist[15:8];
    assign u_t0_tag  = update_i.pc[17:8] ^ u_hist[15:6];
    assign u_t1_tag  = update_i.pc[17:8] ^ {{(TAG_WIDTH-8){1'b0}}, u_hist[7:0]};

    assign bim_miss = update_i.valid && !update_i.correct
                      && (update_i.meta.provider == PROV_BIMODAL);
    assign alloc_t1 = bim_miss && (!t1_vld[u_t1_idx] || (t1_tag[u_t1_idx] != u_t1_tag));
    assign alloc_t0 = bim_miss && !alloc_t1
                      && (!t0_vld[u_t0_idx] || (t0_tag[u_t0_idx] != u_t0_tag));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bim_ctr[i] <= 2'b01;  // weakly not taken
            end
            for (int i = 0; i < TAGE_ENTRIES; i++) begin
                t0_ctr[i] <= 2'b01;
                t1_ctr[i] <= 2'b01;
                t0_vld[i] <= 1'b0;
                t1_vld[i] <= 1'b0;
            end
        end else if (update_i.valid) begin
            ghist              <= {ghist[HIST_WIDTH-2:0], update_i.taken};
            bim_ctr[u_bim_idx] <= sat_ctr(bim_ctr[u_bim_idx], update_i.taken);
            case (update_i.meta.provider)
                PROV_T1: t1_ctr[u_t1_idx] <= update_i.correct
                                             ? sat_ctr(t1_ctr[u_t1_idx], update_i.taken)
                                             : {2{update_i.taken}};
                PROV_T0: t0_ctr[u_t0_idx] <= update_i.correct
                                             ? sat_ctr(t0_ctr[u_t0_idx], update_i.taken)
                                             : {2{update_i.taken}};
                default: begin
                    if (alloc_t1) begin
                        t1_vld[u_t1_idx] <= 1'b1;
                        t1_ctr[u_t1_idx] <= {update_i.taken, !update_i.taken}; // weak
                    end else if (alloc_t0) begin
                        t0_vld[u_t0_idx] <= 1'b1;
                        t0_ctr[u_t0_idx] <= {update_i.taken, !update_i.taken};
                    end
                end
            endcase
        end
    end

    // tag arrays only change on allocation
    always_ff @(posedge clk) begin
        if (alloc_t1) t1_tag[u_t1_idx] <= u_t1_tag;
        if (alloc_t0) t0_tag[u_t0_idx] <= u_t0_tag;
    end

endmodule

`default_nettype wire

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode import bpu_pkg::*; (
    input  wire logic [XLEN-1:0] inst_i,
    output decode_t              decode_o
);

    opcode_e    opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       link_rs1;  // rs1 is ra or t0
    logic       is_ret;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);
    // jalr x0, 0(ra) style return
    assign is_ret   = (rd == 5'd0) && link_rs1 && (inst_i[31:20] == 12'd0);

    always_comb begin
        case (opcode)
            OP_BRANCH: decode_o.cls = CLS_BRANCH;
            OP_JAL:    decode_o.cls = CLS_JAL;
            OP_JALR:   decode_o.cls = is_ret ? CLS_RET : CLS_JALR;
            default:   decode_o.cls = CLS_NONE;
        endcase
    end

    // b-type immediate
    assign decode_o.branch_off = {
        {(XLEN-12){inst_i[31]}},
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // j-type immediate
    assign decode_o.jal_off = {
        {(XLEN-20){inst_i[31]}},
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

endmodule

`default_nettype wire

// ==== logic/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    localparam int XLEN             = 32;
    localparam int HIST_WIDTH       = 16;
    localparam int TAG_WIDTH        = 10;
    localparam int TAGE_INDEX_WIDTH = 8;   // 256 entries per tagged table

    // major opcodes the predictor cares about
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_RET
    } inst_class_e;

    // table that supplied the direction
    typedef enum logic [1:0] {
        PROV_BIMODAL,
        PROV_T0,
        PROV_T1
    } provider_e;

    typedef struct packed {
        inst_class_e       cls;
        logic [XLEN-1:0]   branch_off; // b-type imm, sign extended
        logic [XLEN-1:0]   jal_off;    // j-type imm, sign extended
    } decode_t;

    // rides down the pipe with the instruction
    typedef struct packed {
        provider_e             provider;
        logic [HIST_WIDTH-1:0] history;
    } pred_meta_t;

    typedef struct packed {
        logic              redirect; // control transfer instruction
        logic              taken;
        logic [XLEN-1:0]   target;   // next fetch address
        pred_meta_t        meta;
    } prediction_t;

    // resolved branch info from execute
    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   target;
        logic              ret;
        pred_meta_t        meta;
    } ex_update_t;

endpackage

`default_nettype wire
